/* list.f */
rtl/icache_pkg.sv
rtl/icache_l0.sv
rtl/icache_predecode.sv
rtl/icache_refill_wb.sv
rtl/icache_top.sv
sim/tb_icache_mem.sv
sim/tb_icache.sv

/* rtl/icache_l0.sv */
// L0 instruction cache: tag and data arrays, hit path, round-robin evictor, refill arbitration
`timescale 1ns/1ps
`default_nettype none

module icache_l0 import icache_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  prefetch_en_i,

  input  logic [FETCH_AW-1:0]   fetch_addr_i,
  input  logic                  fetch_valid_i,
  output logic [FETCH_DW-1:0]   fetch_data_o,
  output logic                  fetch_ready_o,

  output logic                  evt_hit_o,
  output logic                  evt_miss_o,
  output logic                  evt_prefetch_o,

  output logic [LINE_WIDTH-1:0] pd_line_o,
  output logic [FETCH_AW-1:0]   pd_addr_o,
  input  logic [FETCH_AW-1:0]   pd_target_i,

  output logic [FETCH_AW-1:0]   rf_req_addr_o,
  output logic                  rf_req_prefetch_o,
  output logic                  rf_req_valid_o,
  input  logic                  rf_req_ready_i,

  input  logic [LINE_WIDTH-1:0] rf_rsp_data_i,
  input  logic                  rf_rsp_valid_i
);

  logic [TAG_WIDTH-1:0]     fetch_tag;
  logic [TAG_WIDTH-1:0]     pf_tag;
  logic [TAG_WIDTH-1:0]     tag_q [L0_LINE_COUNT];
  logic [L0_LINE_COUNT-1:0] valid_q;
  logic [LINE_WIDTH-1:0]    data_q [L0_LINE_COUNT];

  logic [L0_LINE_COUNT-1:0] hit;
  logic [L0_LINE_COUNT-1:0] hit_pf;
  logic                     hit_any;
  logic                     hit_pf_any;
  logic [LINE_WIDTH-1:0]    hit_line;

  logic                     miss;
  logic                     miss_q;
  logic                     evict_miss;
  logic                     latch_pf;
  logic                     evict_req;
  logic [L0_LINE_COUNT-1:0] evict_strb;
  logic [L0_LINE_COUNT-1:0] validate_strb;
  logic [L0_IDX_WIDTH-1:0]  rr_q;

  // Pending refill bookkeeping, one refill in flight at most
  logic                     pending_q;
  logic [L0_LINE_COUNT-1:0] pending_line_q;

  logic                     pf_valid_q;
  logic [FETCH_AW-1:0]      pf_addr_q;

  assign fetch_tag = fetch_addr_i[FETCH_AW-1:LINE_ALIGN];
  assign pf_tag    = pd_target_i[FETCH_AW-1:LINE_ALIGN];

  // ------------------------------
  // Tag compare
  // ------------------------------
  for (genvar i = 0; i < L0_LINE_COUNT; i++) begin : gen_cmp
    assign hit[i]    = valid_q[i] & (tag_q[i] == fetch_tag);
    assign hit_pf[i] = valid_q[i] & (tag_q[i] == pf_tag);
  end

  assign hit_any    = |hit;
  assign hit_pf_any = |hit_pf;
  assign miss       = fetch_valid_i & ~hit_any & ~pending_q;

  // Only the first cycle of a miss picks a victim
  assign evict_miss = miss & ~miss_q;

  // Prefetch when the current hit points at an absent line
  assign latch_pf   = prefetch_en_i & fetch_valid_i & hit_any & ~hit_pf_any & ~pending_q;
  assign evict_req  = evict_miss | latch_pf;

  // ------------------------------
  // Arrays
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      for (int i = 0; i < L0_LINE_COUNT; i++) begin
        tag_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < L0_LINE_COUNT; i++) begin
        if (evict_strb[i]) begin
          // Victim gets its new tag now and stays invalid until the refill lands
          valid_q[i] <= 1'b0;
          tag_q[i]   <= latch_pf ? pf_tag : fetch_tag;
        end else if (validate_strb[i]) begin
          valid_q[i] <= 1'b1;
        end
      end
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < L0_LINE_COUNT; i++) begin
      if (validate_strb[i]) begin
        data_q[i] <= rf_rsp_data_i;
      end
    end
  end

  // Hit line select and word select
  always_comb begin
    hit_line = '0;
    for (int i = 0; i < L0_LINE_COUNT; i++) begin
      hit_line |= {LINE_WIDTH{hit[i]}} & data_q[i];
    end
  end

  assign fetch_data_o  = hit_line[fetch_addr_i[LINE_ALIGN-1:FETCH_ALIGN]*FETCH_DW +: FETCH_DW];
  assign fetch_ready_o = hit_any;

  assign pd_line_o = hit_line;
  assign pd_addr_o = fetch_addr_i;

  // ------------------------------
  // Evictor and refill tracking
  // ------------------------------
  assign evict_strb    = evict_req ? (L0_LINE_COUNT'(1) << rr_q) : '0;
  assign validate_strb = rf_rsp_valid_i ? pending_line_q : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q           <= '0;
      miss_q         <= 1'b0;
      pending_q      <= 1'b0;
      pending_line_q <= '0;
      pf_valid_q     <= 1'b0;
    end else begin
      miss_q <= miss;
      if (evict_req) begin
        rr_q           <= rr_q + 1'b1;
        pending_line_q <= evict_strb;
      end
      if (pending_q) begin
        if (rf_rsp_valid_i) begin
          pending_q <= 1'b0;
        end
      end else if ((miss && rf_req_ready_i) || latch_pf) begin
        pending_q <= 1'b1;
      end
      // Held prefetch leaves once the engine takes it
      if (latch_pf) begin
        pf_valid_q <= 1'b1;
      end else if (rf_req_ready_i && !miss) begin
        pf_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (latch_pf) begin
      pf_addr_q <= {pf_tag, {LINE_ALIGN{1'b0}}};
    end
  end

  // Miss wins over a held prefetch
  assign rf_req_valid_o    = miss | pf_valid_q;
  assign rf_req_prefetch_o = ~miss;
  assign rf_req_addr_o     = miss ? {fetch_tag, {LINE_ALIGN{1'b0}}} : pf_addr_q;

  // ------------------------------
  // Events
  // ------------------------------
  assign evt_hit_o      = fetch_valid_i & hit_any;
  assign evt_miss_o     = evict_miss;
  assign evt_prefetch_o = latch_pf;

  // ------------------------------
  // Assertions
  // ------------------------------
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit));

  // Core must hold the fetch until it is served
  a_fetch_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && !fetch_ready_o |=> fetch_valid_i && $stable(fetch_addr_i));

  a_evict_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(evict_miss && latch_pf));

endmodule

`default_nettype wire

/* rtl/icache_pkg.sv */
// Cache geometry constants, refill FSM states and RISC-V opcodes used by predecode
`default_nettype none

package icache_pkg;

  // ------------------------------
  // Geometry
  // ------------------------------
  localparam int unsigned FETCH_AW       = 32;
  localparam int unsigned FETCH_DW       = 32;
  localparam int unsigned LINE_WIDTH     = 128;
  localparam int unsigned LINE_ALIGN     = 4;
  localparam int unsigned FETCH_ALIGN    = 2;
  localparam int unsigned WORDS_PER_LINE = LINE_WIDTH / FETCH_DW;
  localparam int unsigned L0_LINE_COUNT  = 4;
  localparam int unsigned TAG_WIDTH      = FETCH_AW - LINE_ALIGN;

  // Index widths derived from the geometry
  localparam int unsigned WORD_IDX_WIDTH = LINE_ALIGN - FETCH_ALIGN;
  localparam int unsigned L0_IDX_WIDTH   = $clog2(L0_LINE_COUNT);

  // ------------------------------
  // Refill engine states
  // ------------------------------
  typedef enum logic [1:0] {
    IDLE,
    READ,
    RESP
  } refill_state_e;

  // ------------------------------
  // Major opcodes seen by predecode
  // ------------------------------
  typedef enum logic [6:0] {
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } rv_opcode_e;

endpackage

`default_nettype wire

/* rtl/icache_predecode.sv */
// Line predecoder: finds the first taken branch or JAL and computes the prefetch line address
`timescale 1ns/1ps
`default_nettype none

module icache_predecode import icache_pkg::*; (
  input  logic [LINE_WIDTH-1:0] pd_line_i,
  input  logic [FETCH_AW-1:0]   pd_addr_i,
  output logic [FETCH_AW-1:0]   pd_target_o
);

  logic [WORDS_PER_LINE-1:0] is_branch;
  logic [WORDS_PER_LINE-1:0] is_jal;
  logic [WORDS_PER_LINE-1:0] mask;
  logic [WORD_IDX_WIDTH-1:0] sel_idx;
  logic                      found;
  logic [FETCH_DW-1:0]       sel_word;
  logic [FETCH_AW-1:0]       j_imm;
  logic [FETCH_AW-1:0]       b_imm;
  logic [FETCH_AW-1:0]       base_addr;
  logic [FETCH_AW-1:0]       offset;
  logic [FETCH_AW-1:0]       sum;

  // ------------------------------
  // Per-word classification
  // ------------------------------
  always_comb begin
    rv_opcode_e          opc;
    logic [FETCH_DW-1:0] word;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      word = pd_line_i[i*FETCH_DW +: FETCH_DW];
      opc  = rv_opcode_e'(word[6:0]);
      is_jal[i] = (opc == OPC_JAL);
      // Static prediction: backward conditional branches are taken
      // funct3 010 and 011 are not branches
      is_branch[i] = (opc == OPC_BRANCH) && (word[14:13] != 2'b01) && word[31];
    end
  end

  // Ignore words before the fetch word
  assign mask = {WORDS_PER_LINE{1'b1}} << pd_addr_i[LINE_ALIGN-1:FETCH_ALIGN];

  // Lowest taken word wins
  always_comb begin
    found   = 1'b0;
    sel_idx = '0;
    for (int i = WORDS_PER_LINE - 1; i >= 0; i--) begin
      if (mask[i] && (is_branch[i] || is_jal[i])) begin
        found   = 1'b1;
        sel_idx = WORD_IDX_WIDTH'(i);
      end
    end
  end

  // ------------------------------
  // Target address
  // ------------------------------
  assign sel_word = pd_line_i[sel_idx*FETCH_DW +: FETCH_DW];

  assign j_imm = {{(FETCH_AW-21){sel_word[31]}}, sel_word[31], sel_word[19:12],
                  sel_word[20], sel_word[30:21], 1'b0};
  assign b_imm = {{(FETCH_AW-13){sel_word[31]}}, sel_word[31], sel_word[7],
                  sel_word[30:25], sel_word[11:8], 1'b0};

  always_comb begin
    if (found) begin
      base_addr = {pd_addr_i[FETCH_AW-1:LINE_ALIGN], sel_idx, {FETCH_ALIGN{1'b0}}};
      offset    = is_jal[sel_idx] ? j_imm : b_imm;
    end else begin
      // Next sequential line
      base_addr = pd_addr_i;
      offset    = FETCH_AW'(1 << LINE_ALIGN);
    end
  end

  assign sum         = base_addr + offset;
  assign pd_target_o = {sum[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};

endmodule

`default_nettype wire

/* rtl/icache_refill_wb.sv */
// Refill engine: line request to four Wishbone classic single-word reads, line assembly
`timescale 1ns/1ps
`default_nettype none

module icache_refill_wb import icache_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic [FETCH_AW-1:0]   rf_req_addr_i,
  input  logic                  rf_req_prefetch_i,
  input  logic                  rf_req_valid_i,
  output logic                  rf_req_ready_o,

  output logic [LINE_WIDTH-1:0] rf_rsp_data_o,
  output logic                  rf_rsp_valid_o,

  output logic [FETCH_AW-1:0]   wb_adr_o,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  input  logic [FETCH_DW-1:0]   wb_dat_i,
  input  logic                  wb_ack_i
);

  refill_state_e             state_q;
  logic [TAG_WIDTH-1:0]      base_q;
  logic [WORD_IDX_WIDTH-1:0] beat_q;
  logic                      cyc_q;
  logic                      pf_q;
  logic [LINE_WIDTH-1:0]     line_q;

  // Refill counters, all and prefetch only
  int unsigned               refill_cnt_q;
  int unsigned               pf_cnt_q;

  // ------------------------------
  // FSM
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      beat_q       <= '0;
      cyc_q        <= 1'b0;
      pf_q         <= 1'b0;
      refill_cnt_q <= 0;
      pf_cnt_q     <= 0;
    end else begin
      case (state_q)
        IDLE: begin
          if (rf_req_valid_i) begin
            state_q <= READ;
            cyc_q   <= 1'b1;
            beat_q  <= '0;
            pf_q    <= rf_req_prefetch_i;
          end
        end
        READ: begin
          if (cyc_q && wb_ack_i) begin
            // Drop the cycle between beats
            cyc_q  <= 1'b0;
            beat_q <= beat_q + 1'b1;
            if (beat_q == '1) begin
              state_q <= RESP;
            end
          end else if (!cyc_q) begin
            cyc_q <= 1'b1;
          end
        end
        RESP: begin
          state_q      <= IDLE;
          refill_cnt_q <= refill_cnt_q + 1;
          if (pf_q) begin
            pf_cnt_q <= pf_cnt_q + 1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Line base and data assembly, lowest word arrives first
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && rf_req_valid_i) begin
      base_q <= rf_req_addr_i[FETCH_AW-1:LINE_ALIGN];
    end
    if (state_q == READ && cyc_q && wb_ack_i) begin
      line_q <= {wb_dat_i, line_q[LINE_WIDTH-1:FETCH_DW]};
    end
  end

  assign rf_req_ready_o = (state_q == IDLE);
  assign rf_rsp_valid_o = (state_q == RESP);
  assign rf_rsp_data_o  = line_q;

  assign wb_adr_o = {base_q, beat_q, {FETCH_ALIGN{1'b0}}};
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;

  // ------------------------------
  // Assertions
  // ------------------------------
  a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o |-> wb_cyc_o);

  a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o));

  a_rsp_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_rsp_valid_o |=> !rf_rsp_valid_o);

  // Prefetch refills are a subset of all refills
  a_pf_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pf_cnt_q <= refill_cnt_q);

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
// Instruction cache top level: L0 cache, predecoder and Wishbone refill engine
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                prefetch_en_i,

  input  logic [FETCH_AW-1:0] fetch_addr_i,
  input  logic                fetch_valid_i,
  output logic [FETCH_DW-1:0] fetch_data_o,
  output logic                fetch_ready_o,

  output logic                evt_hit_o,
  output logic                evt_miss_o,
  output logic                evt_prefetch_o,

  output logic [FETCH_AW-1:0] wb_adr_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  input  logic [FETCH_DW-1:0] wb_dat_i,
  input  logic                wb_ack_i
);

  logic [LINE_WIDTH-1:0] pd_line;
  logic [FETCH_AW-1:0]   pd_addr;
  logic [FETCH_AW-1:0]   pd_target;

  logic [FETCH_AW-1:0]   rf_req_addr;
  logic                  rf_req_prefetch;
  logic                  rf_req_valid;
  logic                  rf_req_ready;
  logic [LINE_WIDTH-1:0] rf_rsp_data;
  logic                  rf_rsp_valid;

  icache_l0 i_l0 (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush_i),
    .prefetch_en_i     (prefetch_en_i),
    .fetch_addr_i      (fetch_addr_i),
    .fetch_valid_i     (fetch_valid_i),
    .fetch_data_o      (fetch_data_o),
    .fetch_ready_o     (fetch_ready_o),
    .evt_hit_o         (evt_hit_o),
    .evt_miss_o        (evt_miss_o),
    .evt_prefetch_o    (evt_prefetch_o),
    .pd_line_o         (pd_line),
    .pd_addr_o         (pd_addr),
    .pd_target_i       (pd_target),
    .rf_req_addr_o     (rf_req_addr),
    .rf_req_prefetch_o (rf_req_prefetch),
    .rf_req_valid_o    (rf_req_valid),
    .rf_req_ready_i    (rf_req_ready),
    .rf_rsp_data_i     (rf_rsp_data),
    .rf_rsp_valid_i    (rf_rsp_valid)
  );

  icache_predecode i_predecode (
    .pd_line_i   (pd_line),
    .pd_addr_i   (pd_addr),
    .pd_target_o (pd_target)
  );

  icache_refill_wb i_refill (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rf_req_addr_i     (rf_req_addr),
    .rf_req_prefetch_i (rf_req_prefetch),
    .rf_req_valid_i    (rf_req_valid),
    .rf_req_ready_o    (rf_req_ready),
    .rf_rsp_data_o     (rf_rsp_data),
    .rf_rsp_valid_o    (rf_rsp_valid),
    .wb_adr_o          (wb_adr_o),
    .wb_cyc_o          (wb_cyc_o),
    .wb_stb_o          (wb_stb_o),
    .wb_dat_i          (wb_dat_i),
    .wb_ack_i          (wb_ack_i)
  );

endmodule

`default_nettype wire

/* sim/tb_icache.sv */
// Testbench top: clock and reset, directed cache tests, compare tasks and final report
`timescale 1ns/1ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

  localparam int unsigned FETCH_TIMEOUT = 200;
  localparam int unsigned BEAT_TIMEOUT  = 200;

  logic                clk;
  logic                rst_n;
  logic                flush;
  logic                prefetch_en;
  logic [FETCH_AW-1:0] fetch_addr;
  logic                fetch_valid;
  logic [FETCH_DW-1:0] fetch_data;
  logic                fetch_ready;
  logic                evt_hit;
  logic                evt_miss;
  logic                evt_prefetch;
  logic [FETCH_AW-1:0] wb_adr;
  logic                wb_cyc;
  logic                wb_stb;
  logic [FETCH_DW-1:0] wb_dat;
  logic                wb_ack;
  int unsigned         checks_done;

  icache_top uut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .flush_i        (flush),
    .prefetch_en_i  (prefetch_en),
    .fetch_addr_i   (fetch_addr),
    .fetch_valid_i  (fetch_valid),
    .fetch_data_o   (fetch_data),
    .fetch_ready_o  (fetch_ready),
    .evt_hit_o      (evt_hit),
    .evt_miss_o     (evt_miss),
    .evt_prefetch_o (evt_prefetch),
    .wb_adr_o       (wb_adr),
    .wb_cyc_o       (wb_cyc),
    .wb_stb_o       (wb_stb),
    .wb_dat_i       (wb_dat),
    .wb_ack_i       (wb_ack)
  );

  tb_icache_mem mem (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_adr_i (wb_adr),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_dat_o (wb_dat),
    .wb_ack_o (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------
  // Reference rules
  // ------------------------------
  function automatic logic [FETCH_DW-1:0] default_word(input logic [FETCH_AW-1:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  function automatic logic [FETCH_AW-1:0] line_base(input logic [FETCH_AW-1:0] addr);
    return {addr[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
  endfunction

  // jal x0, imm
  function automatic logic [FETCH_DW-1:0] encode_jal(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, OPC_JAL};
  endfunction

  // Conditional branch comparing x0 with x0
  function automatic logic [FETCH_DW-1:0] encode_branch(input logic [2:0] funct3,
                                                        input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd0, 5'd0, funct3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [FETCH_DW-1:0] got,
                            input logic [FETCH_DW-1:0] exp);
    checks_done++;
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input logic [FETCH_AW-1:0] got,
                            input logic [FETCH_AW-1:0] exp);
    checks_done++;
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks_done++;
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time=%0t signal=%s got=%b expected=%b",
                         $time, name, got, exp));
    end
  endtask

  task automatic expect_count(input int unsigned exp);
    checks_done++;
    if (mem.log_count() != exp) begin
      fail_run($sformatf("Expected %0d bus reads but the memory saw %0d at time %0t",
                         exp, mem.log_count(), $time));
    end
  endtask

  // ------------------------------
  // Drivers
  // ------------------------------
  task automatic wait_beats(input int unsigned n);
    int unsigned cycles;
    cycles = 0;
    while (mem.log_count() < n && cycles < BEAT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (mem.log_count() < n) begin
      fail_run($sformatf("Timed out waiting for %0d bus reads, only %0d arrived",
                         n, mem.log_count()));
    end
  endtask

  // Bus log must hold exactly one line read in word order
  task automatic expect_line_reads(input logic [FETCH_AW-1:0] base);
    wait_beats(WORDS_PER_LINE);
    expect_count(WORDS_PER_LINE);
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      check_addr("wb_adr_o", mem.log_at(i), base + FETCH_AW'(4 * i));
    end
    mem.clear_log();
  endtask

  task automatic run_fetch(input logic [FETCH_AW-1:0] addr, output logic [FETCH_DW-1:0] data,
                           output logic miss_seen, output logic hit_seen,
                           output logic pf_seen);
    int unsigned cycles;
    cycles    = 0;
    miss_seen = 1'b0;
    @(posedge clk);
    fetch_addr  <= addr;
    fetch_valid <= 1'b1;
    @(negedge clk);
    while (!fetch_ready && cycles < FETCH_TIMEOUT) begin
      miss_seen |= evt_miss;
      @(negedge clk);
      cycles++;
    end
    if (!fetch_ready) begin
      fail_run($sformatf("Timed out waiting for fetch_ready_o at address %h", addr));
    end
    miss_seen |= evt_miss;
    data     = fetch_data;
    hit_seen = evt_hit;
    pf_seen  = evt_prefetch;
    @(posedge clk);
    fetch_valid <= 1'b0;
  endtask

  task automatic fetch_miss(input logic [FETCH_AW-1:0] addr, input logic exp_pf);
    logic [FETCH_DW-1:0] data;
    logic                miss_seen;
    logic                hit_seen;
    logic                pf_seen;
    run_fetch(addr, data, miss_seen, hit_seen, pf_seen);
    check_bit("evt_miss_o", miss_seen, 1'b1);
    check_bit("evt_hit_o", hit_seen, 1'b1);
    check_word("fetch_data_o", data, default_word(addr));
    check_bit("evt_prefetch_o", pf_seen, exp_pf);
    expect_line_reads(line_base(addr));
  endtask

  task automatic fetch_hit(input logic [FETCH_AW-1:0] addr, input logic exp_pf);
    logic [FETCH_DW-1:0] data;
    logic                miss_seen;
    logic                hit_seen;
    logic                pf_seen;
    run_fetch(addr, data, miss_seen, hit_seen, pf_seen);
    check_bit("evt_miss_o", miss_seen, 1'b0);
    check_bit("evt_hit_o", hit_seen, 1'b1);
    check_word("fetch_data_o", data, default_word(addr));
    check_bit("evt_prefetch_o", pf_seen, exp_pf);
    expect_count(0);
  endtask

  task automatic flush_cache();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  task automatic set_prefetch(input logic en);
    @(posedge clk);
    prefetch_en <= en;
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_reset_state();
    @(negedge clk);
    check_bit("fetch_ready_o", fetch_ready, 1'b0);
    check_bit("wb_cyc_o", wb_cyc, 1'b0);
    check_bit("wb_stb_o", wb_stb, 1'b0);
    check_bit("evt_hit_o", evt_hit, 1'b0);
    check_bit("evt_miss_o", evt_miss, 1'b0);
    check_bit("evt_prefetch_o", evt_prefetch, 1'b0);
  endtask

  task automatic test_cold_miss();
    set_prefetch(1'b0);
    fetch_miss(32'h0000_1008, 1'b0);
  endtask

  task automatic test_hit();
    fetch_hit(32'h0000_1000, 1'b0);
    fetch_hit(32'h0000_1004, 1'b0);
    fetch_hit(32'h0000_100C, 1'b0);
  endtask

  task automatic test_next_line_prefetch();
    flush_cache();
    set_prefetch(1'b1);
    fetch_miss(32'h0000_2004, 1'b1);
    expect_line_reads(32'h0000_2010);
    // Hit on the prefetched line starts the next one
    fetch_hit(32'h0000_2018, 1'b1);
    expect_line_reads(32'h0000_2020);
  endtask

  task automatic test_target_prefetch();
    flush_cache();
    mem.plant_word(32'h0000_3008, encode_jal(21'd256));
    fetch_miss(32'h0000_3004, 1'b1);
    expect_line_reads(line_base(32'h0000_3008 + 32'd256));

    flush_cache();
    mem.plant_word(32'h0000_400C, encode_branch(3'b000, 13'h1E00));
    fetch_miss(32'h0000_4000, 1'b1);
    expect_line_reads(line_base(32'h0000_400C - 32'd512));

    // Forward branch is predicted not taken
    flush_cache();
    mem.plant_word(32'h0000_5004, encode_branch(3'b001, 13'd64));
    fetch_miss(32'h0000_5000, 1'b1);
    expect_line_reads(32'h0000_5010);
  endtask

  task automatic test_flush();
    set_prefetch(1'b0);
    flush_cache();
    fetch_miss(32'h0000_6000, 1'b0);
    fetch_hit(32'h0000_6004, 1'b0);
    flush_cache();
    fetch_miss(32'h0000_6008, 1'b0);
  endtask

  task automatic test_round_robin();
    flush_cache();
    for (int i = 0; i < 5; i++) begin
      fetch_miss(32'h0000_7000 + FETCH_AW'(16 * i), 1'b0);
    end
    fetch_miss(32'h0000_7008, 1'b0);
    fetch_hit(32'h0000_7044, 1'b0);
  endtask

  initial begin
    rst_n       = 1'b0;
    flush       = 1'b0;
    prefetch_en = 1'b0;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    checks_done = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_state();
    test_cold_miss();
    test_hit();
    test_next_line_prefetch();
    test_target_prefetch();
    test_flush();
    test_round_robin();

    if (checks_done > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_icache_mem.sv */
// Wishbone classic read-only memory model with random wait states, planted words and a beat log
`timescale 1ns/1ps
`default_nettype none

module tb_icache_mem import icache_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [FETCH_AW-1:0] wb_adr_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  output logic [FETCH_DW-1:0] wb_dat_o,
  output logic                wb_ack_o
);

  localparam int unsigned PLANT_SLOTS = 8;

  logic [FETCH_AW-1:0] plant_addr [PLANT_SLOTS];
  logic [FETCH_DW-1:0] plant_data [PLANT_SLOTS];
  int unsigned         plant_cnt = 0;
  logic [FETCH_AW-1:0] beat_log [$];
  int unsigned         wait_left;
  int unsigned         seed_draw;

  // Default contents follow the whole word address, planted words override it
  function automatic logic [FETCH_DW-1:0] read_word(input logic [FETCH_AW-1:0] addr);
    logic [FETCH_DW-1:0] word;
    word = addr ^ 32'hA5A5_0000;
    for (int i = 0; i < plant_cnt; i++) begin
      if (plant_addr[i] == {addr[FETCH_AW-1:FETCH_ALIGN], {FETCH_ALIGN{1'b0}}}) begin
        word = plant_data[i];
      end
    end
    return word;
  endfunction

  task automatic plant_word(input logic [FETCH_AW-1:0] addr, input logic [FETCH_DW-1:0] data);
    if (plant_cnt < PLANT_SLOTS) begin
      plant_addr[plant_cnt] = {addr[FETCH_AW-1:FETCH_ALIGN], {FETCH_ALIGN{1'b0}}};
      plant_data[plant_cnt] = data;
      plant_cnt++;
    end
  endtask

  // ------------------------------
  // Beat log access
  // ------------------------------
  function automatic int unsigned log_count();
    return beat_log.size();
  endfunction

  function automatic logic [FETCH_AW-1:0] log_at(input int unsigned idx);
    return beat_log[idx];
  endfunction

  task automatic clear_log();
    beat_log.delete();
  endtask

  // Slave side, one registered ack per beat after 0 to 3 wait states
  initial begin
    seed_draw = $urandom(5);
    wb_ack_o  = 1'b0;
    wb_dat_o  = '0;
    wait_left = $urandom % 4;
    forever begin
      @(posedge clk_i);
      if (!rst_ni || wb_ack_o || !(wb_cyc_i && wb_stb_i)) begin
        wb_ack_o <= 1'b0;
      end else if (wait_left != 0) begin
        wait_left = wait_left - 1;
      end else begin
        wb_ack_o <= 1'b1;
        wb_dat_o <= read_word(wb_adr_i);
        beat_log.push_back(wb_adr_i);
        wait_left = $urandom % 4;
      end
    end
  end

endmodule

`default_nettype wire
